// ==== all.f ====
verilog/stq_types_pkg.sv
verilog/stq_bus_pkg.sv
verilog/stq_alloc_ctrl.sv
verilog/stq_entry.sv
verilog/stq_fwd_select.sv
verilog/stq_drain_ctrl.sv
verilog/store_queue.sv
dv/store_queue_props.sv
dv/store_queue_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := store_queue_tb
FILELIST   := all.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert --timescale 1ns/100ps -j 0
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/100ps

.PHONY: all lint clean

all:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/store_queue_tb.sv ====
// directed store queue test with a cache model that returns credits after a random delay
// table indices assume STQ_DEPTH of 8; check rows carry the load's age_tail in idx
module store_queue_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import stq_types_pkg::*;
  import stq_bus_pkg::*;

  localparam int STQ_DEPTH   = 8;
  localparam int MEM_CREDITS = 2;
  localparam int N_ROWS      = 39;
  localparam int MAX_CYCLES  = (N_ROWS + 4 * STQ_DEPTH) * 4;
  localparam data_t ADR_A    = 32'h0000_0100;
  localparam data_t ADR_B    = 32'h0000_0204;
  localparam data_t ADR_C    = 32'h0001_0318;

  typedef enum logic [2:0] {
    OP_ALLOC, OP_ADDR, OP_DATA, OP_COMMIT, OP_CHECK, OP_FLUSH, OP_IDLE
  } op_e;

  typedef struct packed {
    op_e   op;
    idx_t  idx;
    data_t val;   // payload, or address of a check
    logic  hit;
    logic  wt;
    data_t exp;
  } row_t;

  localparam row_t TBL [N_ROWS] = '{
    '{OP_ALLOC,  4'd0, 32'h0,         1'b0, 1'b0, 32'h0},
    '{OP_ADDR,   4'd0, ADR_A,         1'b0, 1'b0, 32'h0},
    '{OP_DATA,   4'd0, 32'h1111_0000, 1'b0, 1'b0, 32'h0},
    '{OP_ALLOC,  4'd0, 32'h0,         1'b0, 1'b0, 32'h0},
    '{OP_ADDR,   4'd1, ADR_A,         1'b0, 1'b0, 32'h0},
    '{OP_CHECK,  4'd2, ADR_A,         1'b1, 1'b1, 32'h0},          // youngest match lacks data
    '{OP_CHECK,  4'd1, ADR_A,         1'b1, 1'b0, 32'h1111_0000},  // entry 1 is younger
    '{OP_DATA,   4'd1, 32'h2222_0001, 1'b0, 1'b0, 32'h0},
    '{OP_CHECK,  4'd2, ADR_A,         1'b1, 1'b0, 32'h2222_0001},
    '{OP_ALLOC,  4'd0, 32'h0,         1'b0, 1'b0, 32'h0},
    '{OP_ADDR,   4'd2, ADR_B,         1'b0, 1'b0, 32'h0},
    '{OP_COMMIT, 4'd0, 32'h0,         1'b0, 1'b0, 32'h0},
    '{OP_FLUSH,  4'd0, 32'h0,         1'b0, 1'b0, 32'h0},          // kills entries 1 and 2
    '{OP_CHECK,  4'd3, ADR_B,         1'b0, 1'b0, 32'h0},          // killed entry 2 must not match
    '{OP_ALLOC,  4'd0, 32'h0,         1'b0, 1'b0, 32'h0},          // reuses entry 1
    '{OP_ADDR,   4'd1, ADR_B,         1'b0, 1'b0, 32'h0},
    '{OP_DATA,   4'd1, 32'h3333_0002, 1'b0, 1'b0, 32'h0},
    '{OP_ALLOC,  4'd0, 32'h0,         1'b0, 1'b0, 32'h0},
    '{OP_ADDR,   4'd2, ADR_C,         1'b0, 1'b0, 32'h0},
    '{OP_DATA,   4'd2, 32'h4444_0003, 1'b0, 1'b0, 32'h0},
    '{OP_CHECK,  4'd3, ADR_B,         1'b1, 1'b0, 32'h3333_0002},
    '{OP_COMMIT, 4'd0, 32'h0,         1'b0, 1'b0, 32'h0},
    '{OP_COMMIT, 4'd0, 32'h0,         1'b0, 1'b0, 32'h0},
    '{OP_IDLE,   4'd0, 32'h0,         1'b0, 1'b0, 32'h0},
    '{OP_ALLOC,  4'd0, 32'h0,         1'b0, 1'b0, 32'h0},
    '{OP_ALLOC,  4'd0, 32'h0,         1'b0, 1'b0, 32'h0},
    '{OP_ALLOC,  4'd0, 32'h0,         1'b0, 1'b0, 32'h0},
    '{OP_ALLOC,  4'd0, 32'h0,         1'b0, 1'b0, 32'h0},
    '{OP_ALLOC,  4'd0, 32'h0,         1'b0, 1'b0, 32'h0},
    '{OP_ALLOC,  4'd0, 32'h0,         1'b0, 1'b0, 32'h0},          // wraps to entry 0
    '{OP_ADDR,   4'd7, ADR_C,         1'b0, 1'b0, 32'h0},
    '{OP_DATA,   4'd7, 32'h5555_0004, 1'b0, 1'b0, 32'h0},
    '{OP_CHECK,  4'd0, ADR_C,         1'b1, 1'b0, 32'h5555_0004},  // range wraps, entry 7 youngest
    '{OP_FLUSH,  4'd0, 32'h0,         1'b0, 1'b0, 32'h0},          // kills entries 3 to 0
    '{OP_ALLOC,  4'd0, 32'h0,         1'b0, 1'b0, 32'h0},
    '{OP_ADDR,   4'd3, ADR_A,         1'b0, 1'b0, 32'h0},
    '{OP_DATA,   4'd3, 32'h6666_0005, 1'b0, 1'b0, 32'h0},
    '{OP_CHECK,  4'd4, ADR_A,         1'b1, 1'b0, 32'h6666_0005},
    '{OP_COMMIT, 4'd0, 32'h0,         1'b0, 1'b0, 32'h0}
  };

  logic     clk;
  logic     rst;
  logic     alloc_valid;
  idx_t     alloc_idx;
  upd_req_t addr_upd;
  upd_req_t data_upd;
  logic     commit;
  logic     flush;
  chk_req_t chk_req;
  chk_rsp_t chk_rsp;
  mem_wr_t  mem_wr;
  logic     mem_credit;
  cnt_t     alloc_credit;

  addr_t    sh_addr [STQ_DEPTH];
  data_t    sh_data [STQ_DEPTH];
  mem_wr_t  exp_wr [$];
  int       ret_at [$];  // cycles at which the cache hands back a credit
  idx_t     tail_m;
  idx_t     cmt_m;
  int       uncommitted;
  int       alloc_cred;
  int       outstanding;
  int       cycle;
  int       allocs;
  int       credits_seen;
  int       flush_pend;
  logic     chk_pend;
  row_t     chk_row;

  store_queue #(.STQ_DEPTH(STQ_DEPTH), .MEM_CREDITS(MEM_CREDITS)) u_store_queue (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic report_fail(input string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    $display("Test failed");
    $fatal(1, "first error reached");
  endtask

  task automatic clear_inputs();
    alloc_valid = 1'b0;
    addr_upd    = '0;
    data_upd    = '0;
    commit      = 1'b0;
    flush       = 1'b0;
    chk_req     = '0;
  endtask

  // one cycle: sample the outputs at the falling edge, then drive the cache credit
  task automatic tick();
    mem_wr_t w;
    @(negedge clk);
    cycle++;
    if (cycle > MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test failed");
      $fatal(1, "timeout");
    end
    if (mem_wr.valid) begin
      assert (exp_wr.size() != 0) else report_fail("cache write with no committed store");
      w = exp_wr.pop_front();
      assert (mem_wr == w)
        else report_fail($sformatf("write %h/%h, expected %h/%h",
                                   mem_wr.addr, mem_wr.data, w.addr, w.data));
      outstanding++;
      ret_at.push_back(cycle + 1 + int'($urandom_range(3)));
    end
    assert (outstanding <= MEM_CREDITS) else report_fail("writes exceed cache credits");
    assert (alloc_credit == cnt_t'(flush_pend + int'(mem_wr.valid)))
      else report_fail($sformatf("alloc_credit %0d, expected %0d", alloc_credit,
                                 flush_pend + int'(mem_wr.valid)));
    credits_seen += int'(alloc_credit);
    alloc_cred   += int'(alloc_credit);
    flush_pend    = 0;
    assert (chk_rsp.valid == chk_pend) else report_fail("check response in the wrong cycle");
    if (chk_pend) begin
      assert (chk_rsp.hit == chk_row.hit && chk_rsp.wait_data == chk_row.wt &&
              (!chk_row.hit || chk_row.wt || chk_rsp.data == chk_row.exp))
        else report_fail($sformatf("check got hit %b wait %b data %h, expected %b %b %h",
                                   chk_rsp.hit, chk_rsp.wait_data, chk_rsp.data,
                                   chk_row.hit, chk_row.wt, chk_row.exp));
    end
    chk_pend   = 1'b0;
    mem_credit = 1'b0;
    if (ret_at.size() != 0 && ret_at[0] <= cycle) begin
      void'(ret_at.pop_front());
      mem_credit = 1'b1;
      outstanding--;
    end
  endtask

  task automatic apply_row(input row_t row);
    mem_wr_t w;
    clear_inputs();
    while (row.op == OP_ALLOC && alloc_cred == 0) begin
      tick();  // dispatch holds back
    end
    case (row.op)
      OP_ALLOC: begin
        assert (alloc_idx == tail_m)
          else report_fail($sformatf("alloc_idx %0d, expected %0d", alloc_idx, tail_m));
        alloc_valid = 1'b1;
        tail_m      = idx_t'((int'(tail_m) + 1) % STQ_DEPTH);
        alloc_cred--;
        allocs++;
        uncommitted++;
      end
      OP_ADDR: begin
        addr_upd         = '{valid: 1'b1, idx: row.idx, payload: row.val};
        sh_addr[row.idx] = addr_t'(row.val);
      end
      OP_DATA: begin
        data_upd         = '{valid: 1'b1, idx: row.idx, payload: row.val};
        sh_data[row.idx] = row.val;
      end
      OP_COMMIT: begin
        commit  = 1'b1;
        w.valid = 1'b1;
        w.addr  = sh_addr[cmt_m];
        w.data  = sh_data[cmt_m];
        exp_wr.push_back(w);
        cmt_m = idx_t'((int'(cmt_m) + 1) % STQ_DEPTH);
        uncommitted--;
      end
      OP_CHECK: begin
        chk_req  = '{valid: 1'b1, addr: addr_t'(row.val), age_tail: row.idx};
        chk_pend = 1'b1;
        chk_row  = row;
      end
      OP_FLUSH: begin
        flush       = 1'b1;
        flush_pend  = uncommitted;
        uncommitted = 0;
        tail_m      = cmt_m;  // rewinds past the last commit
      end
      default: ;
    endcase
    tick();
  endtask

  initial begin
    void'($urandom(32'h1dfe_e182));
    clear_inputs();
    rst          = 1'b1;
    mem_credit   = 1'b0;
    tail_m       = '0;
    cmt_m        = '0;
    uncommitted  = 0;
    alloc_cred   = STQ_DEPTH;
    outstanding  = 0;
    cycle        = 0;
    allocs       = 0;
    credits_seen = 0;
    flush_pend   = 0;
    chk_pend     = 1'b0;
    @(posedge clk);
    repeat (5) tick();
    rst = 1'b0;
    for (int r = 0; r < N_ROWS; r++) begin
      apply_row(TBL[r]);
    end
    clear_inputs();
    while (exp_wr.size() != 0 || outstanding != 0) begin
      tick();
    end
    tick();
    if (credits_seen == allocs) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      report_fail($sformatf("%0d allocation credits returned, expected %0d",
                            credits_seen, allocs));
    end
  end

endmodule

// ==== dv/store_queue_props.sv ====
// concurrent checks bound into the store queue top
// the credit bound assumes the cache returns at most one credit per write
module store_queue_props #(
  parameter int STQ_DEPTH   = 8,
  parameter int MEM_CREDITS = 2
) (
  input logic                  clk,
  input logic                  rst,
  input stq_bus_pkg::chk_req_t chk_req,
  input stq_bus_pkg::chk_rsp_t chk_rsp,
  input stq_bus_pkg::mem_wr_t  mem_wr,
  input logic                  mem_credit,
  input stq_types_pkg::cnt_t   alloc_credit
);
  timeunit 1ns;
  timeprecision 100ps;
  import stq_types_pkg::*;

  int outstanding;  // writes not yet answered by a credit

  always_ff @(posedge clk) begin
    if (rst) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(mem_wr.valid) - int'(mem_credit);
    end
  end

  a_reset_idle: assert property (@(posedge clk)
    rst |=> !mem_wr.valid && !chk_rsp.valid && alloc_credit == '0)
    else $error("outputs active right after reset");

  a_chk_latency: assert property (@(posedge clk) disable iff (rst)
    chk_rsp.valid == $past(chk_req.valid))
    else $error("check response not one cycle after its request");

  a_mem_credit_bound: assert property (@(posedge clk) disable iff (rst)
    outstanding + int'(mem_wr.valid) <= MEM_CREDITS)
    else $error("cache writes exceed the credit limit");

  a_alloc_credit_bound: assert property (@(posedge clk) disable iff (rst)
    alloc_credit <= cnt_t'(STQ_DEPTH))
    else $error("more entries returned than the queue holds");

endmodule

bind store_queue store_queue_props #(.STQ_DEPTH(STQ_DEPTH), .MEM_CREDITS(MEM_CREDITS)) u_props (.*);

// ==== verilog/store_queue.sv ====
// store queue top with allocation credits towards dispatch and cache credits
// dispatch starts with STQ_DEPTH credits, the cache side with MEM_CREDITS
module store_queue #(
  parameter int STQ_DEPTH   = 8,
  parameter int MEM_CREDITS = 2
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  alloc_valid,
  output stq_types_pkg::idx_t   alloc_idx,
  input  stq_bus_pkg::upd_req_t addr_upd,
  input  stq_bus_pkg::upd_req_t data_upd,
  input  logic                  commit,
  input  logic                  flush,
  input  stq_bus_pkg::chk_req_t chk_req,
  output stq_bus_pkg::chk_rsp_t chk_rsp,
  output stq_bus_pkg::mem_wr_t  mem_wr,
  input  logic                  mem_credit,
  output stq_types_pkg::cnt_t   alloc_credit
);
  import stq_types_pkg::*;
  import stq_bus_pkg::*;

  logic [STQ_DEPTH-1:0]        alloc_en;
  logic [STQ_DEPTH-1:0]        addr_en;
  logic [STQ_DEPTH-1:0]        data_en;
  logic [STQ_DEPTH-1:0]        commit_en;
  logic [STQ_DEPTH-1:0]        kill_en;
  logic [STQ_DEPTH-1:0]        free_en;
  entry_view_t [STQ_DEPTH-1:0] views;
  idx_t                        head;
  cnt_t                        flush_cnt;
  addr_t                       upd_addr;

  assign upd_addr = addr_t'(addr_upd.payload);

  stq_alloc_ctrl #(.STQ_DEPTH(STQ_DEPTH)) u_alloc_ctrl (
    .clk, .rst, .alloc_valid, .addr_upd, .data_upd, .commit, .flush, .head,
    .alloc_idx, .alloc_en, .addr_en, .data_en, .commit_en, .kill_en, .flush_cnt
  );

  for (genvar i = 0; i < STQ_DEPTH; i++) begin : g_entry
    stq_entry u_entry (
      .clk       (clk),
      .rst       (rst),
      .alloc_en  (alloc_en[i]),
      .addr_en   (addr_en[i]),
      .data_en   (data_en[i]),
      .commit_en (commit_en[i]),
      .kill_en   (kill_en[i]),
      .free_en   (free_en[i]),
      .upd_addr  (upd_addr),
      .upd_data  (data_upd.payload),
      .chk_addr  (chk_req.addr),
      .view      (views[i])
    );
  end

  stq_fwd_select #(.STQ_DEPTH(STQ_DEPTH)) u_fwd_select (
    .clk, .rst, .req(chk_req), .views, .head, .rsp(chk_rsp)
  );

  stq_drain_ctrl #(.STQ_DEPTH(STQ_DEPTH), .MEM_CREDITS(MEM_CREDITS)) u_drain_ctrl (
    .clk, .rst, .views, .mem_credit, .flush_cnt, .head, .free_en, .mem_wr, .alloc_credit
  );

endmodule

// ==== verilog/stq_drain_ctrl.sv ====
// in-order drain of committed stores to the cache under a credit count
// MEM_CREDITS must fit in cnt_t, so at most 31; extra credit pulses are dropped
module stq_drain_ctrl #(
  parameter int STQ_DEPTH   = 8,
  parameter int MEM_CREDITS = 2
) (
  input  logic                                      clk,
  input  logic                                      rst,
  input  stq_bus_pkg::entry_view_t [STQ_DEPTH-1:0]  views,
  input  logic                                      mem_credit,
  input  stq_types_pkg::cnt_t                       flush_cnt,
  output stq_types_pkg::idx_t                       head,
  output logic [STQ_DEPTH-1:0]                      free_en,
  output stq_bus_pkg::mem_wr_t                      mem_wr,
  output stq_types_pkg::cnt_t                       alloc_credit
);
  import stq_types_pkg::*;
  import stq_bus_pkg::*;

  entry_view_t head_view;
  cnt_t        credits;
  logic        drain;
  logic        wr_valid;
  addr_t       wr_addr;
  data_t       wr_data;

  always_comb begin
    head_view = views[0];
    for (int i = 1; i < STQ_DEPTH; i++) begin
      if (head == idx_t'(i)) begin
        head_view = views[i];
      end
    end
  end

  assign drain = (head_view.state == ST_DONE) && (credits != '0);

  always_comb begin
    for (int i = 0; i < STQ_DEPTH; i++) begin
      free_en[i] = drain && (head == idx_t'(i));  // slot freed at the drain edge
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head         <= '0;
      credits      <= cnt_t'(MEM_CREDITS);
      wr_valid     <= 1'b0;
      alloc_credit <= '0;
    end else begin
      if (drain) begin
        head <= ring_next(head, STQ_DEPTH);
      end
      case ({drain, mem_credit})
        2'b10: credits <= credits - 1'b1;
        2'b01: begin
          if (credits != cnt_t'(MEM_CREDITS)) begin
            credits <= credits + 1'b1;
          end
        end
        default: ;  // both or neither leave the count
      endcase
      wr_valid     <= drain;
      alloc_credit <= flush_cnt + cnt_t'(drain);
    end
  end

  always_ff @(posedge clk) begin
    if (drain) begin
      wr_addr <= head_view.addr;
      wr_data <= head_view.data;
    end
  end

  assign mem_wr = '{valid: wr_valid, addr: wr_addr, data: wr_data};

endmodule

// ==== verilog/stq_fwd_select.sv ====
// load check against the stores older than the load, response one cycle later
// age_tail equal to head means no older stores, so a load seen at a full queue gets none
module stq_fwd_select #(
  parameter int STQ_DEPTH = 8
) (
  input  logic                                      clk,
  input  logic                                      rst,
  input  stq_bus_pkg::chk_req_t                     req,
  input  stq_bus_pkg::entry_view_t [STQ_DEPTH-1:0]  views,
  input  stq_types_pkg::idx_t                       head,
  output stq_bus_pkg::chk_rsp_t                     rsp
);
  import stq_types_pkg::*;

  cnt_t  span;
  cnt_t  best_off;
  logic  found;
  logic  best_has_data;
  data_t best_data;
  logic  valid_q;
  logic  hit_q;
  logic  wait_q;
  data_t data_q;

  assign span = ring_dist(req.age_tail, head, STQ_DEPTH);  // older stores sit in [head, age_tail)

  always_comb begin
    cnt_t off;
    found         = 1'b0;
    best_off      = '0;
    best_has_data = 1'b0;
    best_data     = '0;
    for (int i = 0; i < STQ_DEPTH; i++) begin
      off = ring_dist(idx_t'(i), head, STQ_DEPTH);
      if (views[i].match && (off < span) && (!found || off > best_off)) begin
        found         = 1'b1;
        best_off      = off;  // larger offset is younger
        best_has_data = views[i].has_data;
        best_data     = views[i].data;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
      hit_q   <= 1'b0;
      wait_q  <= 1'b0;
    end else begin
      valid_q <= req.valid;
      hit_q   <= req.valid && found;
      wait_q  <= req.valid && found && !best_has_data;
    end
  end

  always_ff @(posedge clk) begin
    data_q <= best_data;
  end

  assign rsp = '{valid: valid_q, hit: hit_q, wait_data: wait_q, data: data_q};

endmodule

// ==== verilog/stq_entry.sv ====
// one store queue slot
// commit is expected only after both the address and the data were written
module stq_entry (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     alloc_en,
  input  logic                     addr_en,
  input  logic                     data_en,
  input  logic                     commit_en,
  input  logic                     kill_en,
  input  logic                     free_en,
  input  stq_types_pkg::addr_t     upd_addr,
  input  stq_types_pkg::data_t     upd_data,
  input  stq_types_pkg::addr_t     chk_addr,
  output stq_bus_pkg::entry_view_t view
);
  import stq_types_pkg::*;

  entry_state_e state;
  logic         has_addr;
  logic         has_data;
  logic         addr_ok;
  logic         data_ok;
  addr_t        addr_q;
  data_t        data_q;

  assign addr_ok = has_addr || addr_en;
  assign data_ok = has_data || data_en;

  always_ff @(posedge clk) begin
    if (rst || kill_en || free_en) begin
      state    <= ST_FREE;
      has_addr <= 1'b0;
      has_data <= 1'b0;
    end else begin
      if (state != ST_FREE) begin
        has_addr <= addr_ok;
        has_data <= data_ok;
      end
      case (state)
        ST_FREE: begin
          if (alloc_en) begin
            state <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (commit_en) begin
            state <= ST_DONE;
          end else if (addr_ok && data_ok) begin
            state <= ST_READY;
          end
        end
        ST_READY: begin
          if (commit_en) begin
            state <= ST_DONE;
          end
        end
        default: ;  // ST_DONE holds until freed
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (addr_en) begin
      addr_q <= upd_addr;
    end
    if (data_en) begin
      data_q <= upd_data;
    end
  end

  assign view = '{state:    state,
                  match:    (state != ST_FREE) && has_addr && (addr_q == chk_addr),
                  has_data: has_data,
                  addr:     addr_q,
                  data:     data_q};

endmodule

// ==== verilog/stq_alloc_ctrl.sv ====
// tail and commit pointers, one-hot enable decode and flush rewind
// alloc_valid is ignored in a flush cycle; a commit in that cycle is kept
module stq_alloc_ctrl #(
  parameter int STQ_DEPTH = 8
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  alloc_valid,
  input  stq_bus_pkg::upd_req_t addr_upd,
  input  stq_bus_pkg::upd_req_t data_upd,
  input  logic                  commit,
  input  logic                  flush,
  input  stq_types_pkg::idx_t   head,
  output stq_types_pkg::idx_t   alloc_idx,
  output logic [STQ_DEPTH-1:0]  alloc_en,
  output logic [STQ_DEPTH-1:0]  addr_en,
  output logic [STQ_DEPTH-1:0]  data_en,
  output logic [STQ_DEPTH-1:0]  commit_en,
  output logic [STQ_DEPTH-1:0]  kill_en,
  output stq_types_pkg::cnt_t   flush_cnt
);
  import stq_types_pkg::*;

  idx_t tail;
  idx_t cmt;
  idx_t cmt_eff;
  cnt_t uc_cnt;      // allocated but not committed
  cnt_t uc_eff;
  cnt_t kill_base;
  logic alloc_ok;

  assign alloc_ok  = alloc_valid && !flush;
  assign cmt_eff   = commit ? ring_next(cmt, STQ_DEPTH) : cmt;
  assign uc_eff    = uc_cnt - cnt_t'(commit);
  assign kill_base = ring_dist(cmt_eff, head, STQ_DEPTH);  // committed entries ahead of the window
  assign flush_cnt = flush ? uc_eff : '0;
  assign alloc_idx = tail;

  always_comb begin
    cnt_t off;
    for (int i = 0; i < STQ_DEPTH; i++) begin
      off          = ring_dist(idx_t'(i), head, STQ_DEPTH);
      alloc_en[i]  = alloc_ok && (tail == idx_t'(i));
      addr_en[i]   = addr_upd.valid && (addr_upd.idx == idx_t'(i));
      data_en[i]   = data_upd.valid && (data_upd.idx == idx_t'(i));
      commit_en[i] = commit && (cmt == idx_t'(i));
      kill_en[i]   = flush && (off >= kill_base) && (off < kill_base + uc_eff);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      tail   <= '0;
      cmt    <= '0;
      uc_cnt <= '0;
    end else begin
      cmt <= cmt_eff;
      if (flush) begin
        tail   <= cmt_eff;  // rewind past the last committed store
        uc_cnt <= '0;
      end else begin
        if (alloc_ok) begin
          tail <= ring_next(tail, STQ_DEPTH);
        end
        uc_cnt <= uc_eff + cnt_t'(alloc_ok);
      end
    end
  end

endmodule

// ==== verilog/stq_bus_pkg.sv ====
// request and response buses of the store queue
// all stores are full 32-bit words at a word address
package stq_bus_pkg;
  import stq_types_pkg::*;

  // address updates take the low ADDR_W bits of payload
  typedef struct packed {
    logic  valid;
    idx_t  idx;
    data_t payload;
  } upd_req_t;

  typedef struct packed {
    logic  valid;
    addr_t addr;
    idx_t  age_tail;  // tail seen at load dispatch
  } chk_req_t;

  typedef struct packed {
    logic  valid;
    logic  hit;
    logic  wait_data;  // youngest older match has no data yet
    data_t data;
  } chk_rsp_t;

  typedef struct packed {
    entry_state_e state;
    logic         match;
    logic         has_data;
    addr_t        addr;
    data_t        data;
  } entry_view_t;

  typedef struct packed {
    logic  valid;
    addr_t addr;
    data_t data;
  } mem_wr_t;

endpackage

// ==== verilog/stq_types_pkg.sv ====
// widths, pointer helpers and the entry state encoding of the store queue
// IDX_W is fixed at 4, so STQ_DEPTH can be any power of two from 2 to 16
package stq_types_pkg;

  localparam int IDX_W  = 4;
  localparam int ADDR_W = 30;  // word address, byte offset not kept
  localparam int DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [IDX_W-1:0]  idx_t;
  typedef logic [IDX_W:0]    cnt_t;

  typedef enum logic [1:0] {
    ST_FREE,
    ST_WAIT,   // allocated, address or data still missing
    ST_READY,  // address and data present
    ST_DONE    // committed, waiting to drain
  } entry_state_e;

  // next slot on a ring of depth entries
  function automatic idx_t ring_next(idx_t p, int depth);
    return (int'(p) == depth - 1) ? '0 : p + 1'b1;
  endfunction

  // number of steps from 'from' forward to 'to'
  function automatic cnt_t ring_dist(idx_t to, idx_t from, int depth);
    if (to >= from) begin
      return cnt_t'(to) - cnt_t'(from);
    end
    return cnt_t'(to) + cnt_t'(depth) - cnt_t'(from);
  endfunction

endpackage
